/* all.f */
src/alu_isa_pkg.sv
src/alu_cfg_pkg.sv
src/fu_if.sv
src/issue_queue.sv
src/alu_exec.sv
src/pipeline_alu.sv
testbench/tb_pipeline_alu.sv

/* run.sh */
#!/bin/sh
# Build the ALU lane testbench with Verilator, run it, and look for the pass line
verilator --binary --assert --top-module tb_pipeline_alu -f all.f \
   && out="$(./obj_dir/Vtb_pipeline_alu)" \
   && printf '%s\n' "$out" \
   && printf '%s\n' "$out" | grep -qF '** PASS **' \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

/* src/alu_cfg_pkg.sv */
// Sizing of the ALU lane: issue queue depth and reorder-buffer id width
package alu_cfg_pkg;

   // Issue queue entries, kept a power of two
   localparam int IQ_DEPTH_LOG2 = 2;
   localparam int IQ_DEPTH      = 1 << IQ_DEPTH_LOG2;

   // Micro-op id from the reorder buffer
   localparam int ROB_AW        = 4;

endpackage

/* src/alu_exec.sv */
// alu_exec: opcode decode, ALU compute, branch flags, one-entry writeback stage
`timescale 1ns/100ps

module alu_exec
(
   input  logic                              clk,
   input  logic                              i_rst,
   input  logic                              i_flush,
   // From the issue queue
   fu_if.fu                                  fu,
   // To writeback
   input  logic                              i_wb_ready,
   output logic                              o_wb_valid,
   output logic [alu_isa_pkg::DATA_W-1:0]    o_wb_data,
   output logic [alu_cfg_pkg::ROB_AW-1:0]    o_wb_id,
   output logic                              o_wb_branch_op,
   output logic                              o_wb_branch_rel_taken,
   output logic                              o_wb_branch_reg_taken
);

   logic [alu_isa_pkg::REL_W-1:0]   rel15;
   logic [alu_isa_pkg::OPC_W-1:0]   opc;
   logic [alu_isa_pkg::N_OPS-1:0]   opc_bus;    // One-hot opcode
   logic [alu_isa_pkg::DATA_W-1:0]  rel_sext;   // Branch offset, sign-extended
   logic [alu_isa_pkg::DATA_W-1:0]  res_data;
   logic                            res_br_op;
   logic                            res_rel_taken;
   logic                            res_reg_taken;
   logic                            fu_fire;

   // Unpack micro-op
   assign {rel15, opc} = fu.uop;

   // Decode to one-hot, bit i-1 for opcode i
   for (genvar i = 1; i <= alu_isa_pkg::N_OPS; i++)
   begin : gen_opc_bus
      assign opc_bus[i-1] = (opc == (alu_isa_pkg::OPC_W)'(i));
   end

   assign rel_sext = {{(alu_isa_pkg::DATA_W - alu_isa_pkg::REL_W){rel15[alu_isa_pkg::REL_W-1]}},
                      rel15};

   // Result and flag select
   always_comb
   begin
      res_data      = '0;   // No-op default
      res_br_op     = 1'b0;
      res_rel_taken = 1'b0;
      res_reg_taken = 1'b0;
      case (1'b1)
         opc_bus[alu_isa_pkg::OPC_ADD-1]: res_data = fu.op1 + fu.op2;
         opc_bus[alu_isa_pkg::OPC_SUB-1]: res_data = fu.op1 - fu.op2;
         opc_bus[alu_isa_pkg::OPC_AND-1]: res_data = fu.op1 & fu.op2;
         opc_bus[alu_isa_pkg::OPC_OR-1]:  res_data = fu.op1 | fu.op2;
         opc_bus[alu_isa_pkg::OPC_XOR-1]: res_data = fu.op1 ^ fu.op2;
         opc_bus[alu_isa_pkg::OPC_SLL-1]: res_data = fu.op1 << fu.op2[4:0];
         opc_bus[alu_isa_pkg::OPC_SRL-1]: res_data = fu.op1 >> fu.op2[4:0];
         opc_bus[alu_isa_pkg::OPC_SLT-1]:
            res_data = {{(alu_isa_pkg::DATA_W - 1){1'b0}}, $signed(fu.op1) < $signed(fu.op2)};
         opc_bus[alu_isa_pkg::OPC_BEQ-1]:
         begin
            res_data      = rel_sext;   // Target offset for the branch unit
            res_br_op     = 1'b1;
            res_rel_taken = (fu.op1 == fu.op2);
         end
         opc_bus[alu_isa_pkg::OPC_BNE-1]:
         begin
            res_data      = rel_sext;
            res_br_op     = 1'b1;
            res_rel_taken = (fu.op1 != fu.op2);
         end
         opc_bus[alu_isa_pkg::OPC_JR-1]:
         begin
            res_data      = fu.op1;     // Register target
            res_br_op     = 1'b1;
            res_reg_taken = 1'b1;
         end
         default: ;
      endcase
   end

   // Take a new op when the stage is empty or draining
   assign fu.ready = ~o_wb_valid | i_wb_ready;
   assign fu_fire  = fu.valid & fu.ready;

   always_ff @(posedge clk)
   begin
      if (i_rst || i_flush)
         o_wb_valid <= 1'b0;
      else if (fu.ready)
         o_wb_valid <= fu.valid;   // Refill or go empty
   end

   // Result registers, held while stalled
   always_ff @(posedge clk)
   begin
      if (fu_fire)
      begin
         o_wb_data             <= res_data;
         o_wb_id               <= fu.id;
         o_wb_branch_op        <= res_br_op;
         o_wb_branch_rel_taken <= res_rel_taken;
         o_wb_branch_reg_taken <= res_reg_taken;
      end
   end

   // Decoder never raises two opcodes
   a_opc_onehot : assert property (@(posedge clk) disable iff (i_rst)
      fu.valid |-> $onehot0(opc_bus));

   // Stalled result stays put until writeback takes it
   a_wb_hold : assert property (@(posedge clk) disable iff (i_rst)
      o_wb_valid && !i_wb_ready && !i_flush |=>
         o_wb_valid && $stable(o_wb_data) && $stable(o_wb_id) && $stable(o_wb_branch_op)
         && $stable(o_wb_branch_rel_taken) && $stable(o_wb_branch_reg_taken));

endmodule

/* src/alu_isa_pkg.sv */
// ALU lane ISA: data and field widths, micro-op layout, opcode encoding
package alu_isa_pkg;

   localparam int DATA_W = 32;   // Operand and result width
   localparam int REG_AW = 5;    // Architectural register address
   localparam int OPC_W  = 4;    // Opcode field
   localparam int REL_W  = 15;   // Relative branch offset field

   // Micro-op is {rel15, opc}, offset on top
   localparam int UOP_W  = REL_W + OPC_W;

   // One-hot opcode bus, bit i-1 for opcode i
   localparam int N_OPS  = 11;

   // Opcode values, 0 does nothing
   typedef enum logic [OPC_W-1:0]
   {
      OPC_NOP = 4'd0,
      OPC_ADD = 4'd1,
      OPC_SUB = 4'd2,
      OPC_AND = 4'd3,
      OPC_OR  = 4'd4,
      OPC_XOR = 4'd5,
      OPC_SLL = 4'd6,   // Shift left logical
      OPC_SRL = 4'd7,   // Shift right logical
      OPC_SLT = 4'd8,   // Signed set-less-than
      OPC_BEQ = 4'd9,   // Relative branch if equal
      OPC_BNE = 4'd10,  // Relative branch if not equal
      OPC_JR  = 4'd11   // Jump to register
   } alu_opc_e;

endpackage

/* src/fu_if.sv */
// fu_if: selected micro-op bus from the issue queue to the ALU, iq and fu modports
`timescale 1ns/100ps

interface fu_if;

   logic                            valid;   // Entry ready to leave the queue
   logic                            ready;   // ALU can take it
   logic [alu_cfg_pkg::ROB_AW-1:0]  id;
   logic [alu_isa_pkg::UOP_W-1:0]   uop;     // {rel15, opc}
   logic [alu_isa_pkg::DATA_W-1:0]  op1;
   logic [alu_isa_pkg::DATA_W-1:0]  op2;

   // Issue queue side
   modport iq
   (
      output valid, id, uop, op1, op2,
      input  ready
   );

   // Functional unit side
   modport fu
   (
      input  valid, id, uop, op1, op2,
      output ready
   );

endinterface

/* src/issue_queue.sv */
// issue_queue: out-of-order issue queue with bypass wakeup and lowest-index select
`timescale 1ns/100ps

module issue_queue
(
   input  logic                              clk,
   input  logic                              i_rst,
   input  logic                              i_flush,
   // From dispatch
   input  logic                              i_issue_valid,
   output logic                              o_issue_ready,
   input  logic [alu_isa_pkg::UOP_W-1:0]     i_uop,
   input  logic [alu_cfg_pkg::ROB_AW-1:0]    i_id,
   input  logic                              i_rs1_rdy,
   input  logic [alu_isa_pkg::DATA_W-1:0]    i_rs1_dat,
   input  logic [alu_isa_pkg::REG_AW-1:0]    i_rs1_addr,
   input  logic                              i_rs2_rdy,
   input  logic [alu_isa_pkg::DATA_W-1:0]    i_rs2_dat,
   input  logic [alu_isa_pkg::REG_AW-1:0]    i_rs2_addr,
   // Result bypass broadcast
   input  logic                              i_byp_valid,
   input  logic [alu_isa_pkg::DATA_W-1:0]    i_byp_data,
   input  logic                              i_byp_rd_we,
   input  logic [alu_isa_pkg::REG_AW-1:0]    i_byp_rd_addr,
   // To the ALU
   fu_if.iq                                  fu
);

   // Lowest set bit of a request vector
   function automatic logic [alu_cfg_pkg::IQ_DEPTH_LOG2-1:0] first_set
   (
      input logic [alu_cfg_pkg::IQ_DEPTH-1:0] req
   );
      first_set = '0;
      for (int k = alu_cfg_pkg::IQ_DEPTH - 1; k >= 0; k--)
      begin
         if (req[k])
            first_set = k[alu_cfg_pkg::IQ_DEPTH_LOG2-1:0];   // Lower index wins
      end
   endfunction

   // Entry state, operand index 0 is rs1 and 1 is rs2
   logic [alu_cfg_pkg::IQ_DEPTH-1:0]   ent_vld;
   logic [alu_isa_pkg::UOP_W-1:0]      uop_q      [alu_cfg_pkg::IQ_DEPTH];
   logic [alu_cfg_pkg::ROB_AW-1:0]     id_q       [alu_cfg_pkg::IQ_DEPTH];
   logic                               opr_rdy_q  [2][alu_cfg_pkg::IQ_DEPTH];
   logic [alu_isa_pkg::DATA_W-1:0]     opr_dat_q  [2][alu_cfg_pkg::IQ_DEPTH];
   logic [alu_isa_pkg::REG_AW-1:0]     opr_addr_q [2][alu_cfg_pkg::IQ_DEPTH];

   // Incoming operands as arrays
   logic                               in_rdy  [2];
   logic [alu_isa_pkg::DATA_W-1:0]     in_dat  [2];
   logic [alu_isa_pkg::REG_AW-1:0]     in_addr [2];
   logic                               in_hit  [2];   // Woken in the accept cycle

   logic                               byp_wr;
   logic [alu_cfg_pkg::IQ_DEPTH-1:0]   eligible;
   logic [alu_cfg_pkg::IQ_DEPTH_LOG2-1:0] wr_idx;
   logic [alu_cfg_pkg::IQ_DEPTH_LOG2-1:0] sel_idx;
   logic                               accept;
   logic                               issue;

   assign in_rdy[0]  = i_rs1_rdy;
   assign in_dat[0]  = i_rs1_dat;
   assign in_addr[0] = i_rs1_addr;
   assign in_rdy[1]  = i_rs2_rdy;
   assign in_dat[1]  = i_rs2_dat;
   assign in_addr[1] = i_rs2_addr;

   assign byp_wr = i_byp_valid & i_byp_rd_we;   // Broadcast carries a register write

   always_comb
   begin
      for (int j = 0; j < 2; j++)
         in_hit[j] = byp_wr & ~in_rdy[j] & (in_addr[j] == i_byp_rd_addr);
   end

   // Both operands in hand
   always_comb
   begin
      for (int k = 0; k < alu_cfg_pkg::IQ_DEPTH; k++)
         eligible[k] = ent_vld[k] & opr_rdy_q[0][k] & opr_rdy_q[1][k];
   end

   // Insert side, nothing taken during flush
   assign o_issue_ready = ~(&ent_vld) & ~i_flush;
   assign wr_idx        = first_set(~ent_vld);
   assign accept        = i_issue_valid & o_issue_ready;

   // Select side
   assign sel_idx  = first_set(eligible);
   assign fu.valid = |eligible;
   assign fu.id    = id_q[sel_idx];
   assign fu.uop   = uop_q[sel_idx];
   assign fu.op1   = opr_dat_q[0][sel_idx];
   assign fu.op2   = opr_dat_q[1][sel_idx];
   assign issue    = fu.valid & fu.ready;

   // Occupancy
   always_ff @(posedge clk)
   begin
      if (i_rst || i_flush)
         ent_vld <= '0;
      else
      begin
         for (int k = 0; k < alu_cfg_pkg::IQ_DEPTH; k++)
         begin
            if (issue && int'(sel_idx) == k)
               ent_vld[k] <= 1'b0;   // Gone to the ALU
            if (accept && int'(wr_idx) == k)
               ent_vld[k] <= 1'b1;   // Never the issuing entry
         end
      end
   end

   // Payload capture and operand wakeup
   always_ff @(posedge clk)
   begin
      for (int k = 0; k < alu_cfg_pkg::IQ_DEPTH; k++)
      begin
         if (accept && int'(wr_idx) == k)
         begin
            uop_q[k] <= i_uop;
            id_q[k]  <= i_id;
            for (int j = 0; j < 2; j++)
            begin
               opr_rdy_q[j][k]  <= in_rdy[j] | in_hit[j];
               opr_dat_q[j][k]  <= in_hit[j] ? i_byp_data : in_dat[j];
               opr_addr_q[j][k] <= in_addr[j];
            end
         end
         else
         begin
            for (int j = 0; j < 2; j++)
            begin
               // Waiting operand snoops the bypass bus
               if (byp_wr && !opr_rdy_q[j][k] && opr_addr_q[j][k] == i_byp_rd_addr)
               begin
                  opr_rdy_q[j][k] <= 1'b1;
                  opr_dat_q[j][k] <= i_byp_data;
               end
            end
         end
      end
   end

   // Accept only into a free slot, which holds the micro-op next cycle
   a_accept_free : assert property (@(posedge clk) disable iff (i_rst)
      accept |-> !ent_vld[wr_idx] ##1 ent_vld[$past(wr_idx)]);

   // Selected entry is live and freed once it leaves
   a_issue_live : assert property (@(posedge clk) disable iff (i_rst)
      issue |-> ent_vld[sel_idx] ##1 !ent_vld[$past(sel_idx)]);

endmodule

/* src/pipeline_alu.sv */
// pipeline_alu: ALU lane top, issue queue feeding the ALU over fu_if
`timescale 1ns/100ps

module pipeline_alu
(
   input  logic                              clk,
   input  logic                              i_rst,
   input  logic                              i_flush,
   // From dispatch
   input  logic                              i_issue_valid,
   output logic                              o_issue_ready,
   input  logic [alu_isa_pkg::UOP_W-1:0]     i_issue_uop,
   input  logic [alu_cfg_pkg::ROB_AW-1:0]    i_issue_id,
   input  logic                              i_rs1_rdy,
   input  logic [alu_isa_pkg::DATA_W-1:0]    i_rs1_dat,
   input  logic [alu_isa_pkg::REG_AW-1:0]    i_rs1_addr,
   input  logic                              i_rs2_rdy,
   input  logic [alu_isa_pkg::DATA_W-1:0]    i_rs2_dat,
   input  logic [alu_isa_pkg::REG_AW-1:0]    i_rs2_addr,
   // Bypass broadcast
   input  logic                              i_byp_valid,
   input  logic [alu_isa_pkg::DATA_W-1:0]    i_byp_data,
   input  logic                              i_byp_rd_we,
   input  logic [alu_isa_pkg::REG_AW-1:0]    i_byp_rd_addr,
   // To writeback
   input  logic                              i_wb_ready,
   output logic                              o_wb_valid,
   output logic [alu_isa_pkg::DATA_W-1:0]    o_wb_data,
   output logic [alu_cfg_pkg::ROB_AW-1:0]    o_wb_id,
   output logic                              o_wb_branch_op,
   output logic                              o_wb_branch_rel_taken,
   output logic                              o_wb_branch_reg_taken
);

   fu_if fu_bus ();   // Queue to ALU

   issue_queue u_issue_queue
   (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_flush       (i_flush),
      .i_issue_valid (i_issue_valid),
      .o_issue_ready (o_issue_ready),
      .i_uop         (i_issue_uop),
      .i_id          (i_issue_id),
      .i_rs1_rdy     (i_rs1_rdy),
      .i_rs1_dat     (i_rs1_dat),
      .i_rs1_addr    (i_rs1_addr),
      .i_rs2_rdy     (i_rs2_rdy),
      .i_rs2_dat     (i_rs2_dat),
      .i_rs2_addr    (i_rs2_addr),
      .i_byp_valid   (i_byp_valid),
      .i_byp_data    (i_byp_data),
      .i_byp_rd_we   (i_byp_rd_we),
      .i_byp_rd_addr (i_byp_rd_addr),
      .fu            (fu_bus.iq)
   );

   alu_exec u_alu_exec
   (
      .clk                   (clk),
      .i_rst                 (i_rst),
      .i_flush               (i_flush),
      .fu                    (fu_bus.fu),
      .i_wb_ready            (i_wb_ready),
      .o_wb_valid            (o_wb_valid),
      .o_wb_data             (o_wb_data),
      .o_wb_id               (o_wb_id),
      .o_wb_branch_op        (o_wb_branch_op),
      .o_wb_branch_rel_taken (o_wb_branch_rel_taken),
      .o_wb_branch_reg_taken (o_wb_branch_reg_taken)
   );

endmodule

/* testbench/tb_pipeline_alu.sv */
// ALU lane testbench: LFSR stimulus, reference model, id scoreboard, writeback checks
`timescale 1ns/100ps

module tb_pipeline_alu;

   localparam int MAX_CYCLES = 4000;   // About 300 micro-ops at 10 cycles each, plus margin
   localparam int N_IDS      = 1 << alu_cfg_pkg::ROB_AW;

   // Expected writeback of one micro-op
   typedef struct packed
   {
      logic [alu_isa_pkg::DATA_W-1:0] data;
      logic                           br_op;
      logic                           rel_taken;
      logic                           reg_taken;
   } exp_t;

   logic                            clk = 1'b0;
   logic                            i_rst;
   logic                            i_flush;
   logic                            i_issue_valid;
   logic                            o_issue_ready;
   logic [alu_isa_pkg::UOP_W-1:0]   i_issue_uop;
   logic [alu_cfg_pkg::ROB_AW-1:0]  i_issue_id;
   logic                            i_rs1_rdy;
   logic [alu_isa_pkg::DATA_W-1:0]  i_rs1_dat;
   logic [alu_isa_pkg::REG_AW-1:0]  i_rs1_addr;
   logic                            i_rs2_rdy;
   logic [alu_isa_pkg::DATA_W-1:0]  i_rs2_dat;
   logic [alu_isa_pkg::REG_AW-1:0]  i_rs2_addr;
   logic                            i_byp_valid;
   logic [alu_isa_pkg::DATA_W-1:0]  i_byp_data;
   logic                            i_byp_rd_we;
   logic [alu_isa_pkg::REG_AW-1:0]  i_byp_rd_addr;
   logic                            i_wb_ready = 1'b1;
   logic                            o_wb_valid;
   logic [alu_isa_pkg::DATA_W-1:0]  o_wb_data;
   logic [alu_cfg_pkg::ROB_AW-1:0]  o_wb_id;
   logic                            o_wb_branch_op;
   logic                            o_wb_branch_rel_taken;
   logic                            o_wb_branch_reg_taken;

   // Scoreboard, an id is in flight while its two toggles differ
   exp_t                            exp_tab [N_IDS];
   logic [N_IDS-1:0]                sent_tgl = '0;   // Flipped at send
   logic [N_IDS-1:0]                done_tgl = '0;   // Flipped at writeback
   logic [alu_cfg_pkg::ROB_AW-1:0]  next_id = '0;
   logic [alu_cfg_pkg::ROB_AW-1:0]  last_id;

   logic [31:0]                     lfsr = 32'hd78c;       // Stimulus stream
   logic [31:0]                     rdy_lfsr = 32'hd78c;   // Writeback ready stream
   int                              ready_mode = 0;        // 0 always, 1 random, 2 never
   int                              cycle = 0;
   int                              n_val_err = 0;
   int                              n_id_err = 0;
   int                              n_hold_err = 0;
   int                              n_dir_err = 0;
   int                              n_wb = 0;
   logic                            hold_chk = 1'b0;       // Stalled last edge
   exp_t                            held;
   logic [alu_cfg_pkg::ROB_AW-1:0]  held_id;

   pipeline_alu pipeline_alu_i (.*);

   always #20 clk = ~clk;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int b = 0; b < n; b++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};   // One step per bit
      end
   endtask

   // Expected data and branch flags of one micro-op
   function automatic exp_t alu_ref
   (
      input logic [alu_isa_pkg::OPC_W-1:0]  opc,
      input logic [alu_isa_pkg::REL_W-1:0]  rel,
      input logic [alu_isa_pkg::DATA_W-1:0] a,
      input logic [alu_isa_pkg::DATA_W-1:0] b
   );
      exp_t e;
      e = '0;   // No-op
      case (opc)
         alu_isa_pkg::OPC_ADD: e.data = a + b;
         alu_isa_pkg::OPC_SUB: e.data = a - b;
         alu_isa_pkg::OPC_AND: e.data = a & b;
         alu_isa_pkg::OPC_OR:  e.data = a | b;
         alu_isa_pkg::OPC_XOR: e.data = a ^ b;
         alu_isa_pkg::OPC_SLL: e.data = a << b[4:0];
         alu_isa_pkg::OPC_SRL: e.data = a >> b[4:0];
         alu_isa_pkg::OPC_SLT: e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         alu_isa_pkg::OPC_BEQ, alu_isa_pkg::OPC_BNE:
         begin
            e.data      = {{(alu_isa_pkg::DATA_W - alu_isa_pkg::REL_W){rel[14]}}, rel};
            e.br_op     = 1'b1;
            e.rel_taken = (opc == alu_isa_pkg::OPC_BEQ) ? (a == b) : (a != b);
         end
         alu_isa_pkg::OPC_JR:
         begin
            e.data      = a;   // Jump target
            e.br_op     = 1'b1;
            e.reg_taken = 1'b1;
         end
         default: e = '0;
      endcase
      return e;
   endfunction

   task automatic send_uop
   (
      input logic [alu_isa_pkg::OPC_W-1:0]  opc,
      input logic [alu_isa_pkg::REL_W-1:0]  rel,
      input logic                           rdy1,
      input logic [alu_isa_pkg::DATA_W-1:0] v1,     // Value the ALU must see
      input logic [alu_isa_pkg::REG_AW-1:0] a1,
      input logic                           rdy2,
      input logic [alu_isa_pkg::DATA_W-1:0] v2,
      input logic [alu_isa_pkg::REG_AW-1:0] a2,
      input logic                           byp_now   // Broadcast v1 to a1 in the accept cycle
   );
      while (sent_tgl[next_id] != done_tgl[next_id])   // Id still in flight
         @(negedge clk);
      last_id           = next_id;
      next_id           = next_id + 1'b1;
      exp_tab[last_id]  = alu_ref(opc, rel, v1, v2);
      sent_tgl[last_id] = ~sent_tgl[last_id];
      i_issue_valid = 1'b1;
      i_issue_uop   = {rel, opc};
      i_issue_id    = last_id;
      i_rs1_rdy     = rdy1;
      i_rs1_dat     = rdy1 ? v1 : ~v1;   // Stale value when waiting
      i_rs1_addr    = a1;
      i_rs2_rdy     = rdy2;
      i_rs2_dat     = rdy2 ? v2 : ~v2;
      i_rs2_addr    = a2;
      if (byp_now)
      begin
         i_byp_valid   = 1'b1;
         i_byp_rd_we   = 1'b1;
         i_byp_rd_addr = a1;
         i_byp_data    = v1;
      end
      while (!o_issue_ready)   // Stable until the next rising edge
         @(negedge clk);
      @(negedge clk);   // Accepted on the edge in between
      i_issue_valid = 1'b0;
      i_byp_valid   = 1'b0;
      i_byp_rd_we   = 1'b0;
   endtask

   task automatic send_ready
   (
      input logic [alu_isa_pkg::OPC_W-1:0]  opc,
      input logic [alu_isa_pkg::REL_W-1:0]  rel,
      input logic [alu_isa_pkg::DATA_W-1:0] a,
      input logic [alu_isa_pkg::DATA_W-1:0] b
   );
      send_uop(opc, rel, 1'b1, a, 5'd0, 1'b1, b, 5'd0, 1'b0);
   endtask

   task automatic send_random();
      logic [31:0] r_opc;
      logic [31:0] r_rel;
      logic [31:0] r_a;
      logic [31:0] r_b;
      logic [31:0] r_eq;
      logic [alu_isa_pkg::OPC_W-1:0] opc;
      take_bits(4, r_opc);
      take_bits(15, r_rel);
      take_bits(32, r_a);
      take_bits(32, r_b);
      take_bits(2, r_eq);
      opc = (alu_isa_pkg::OPC_W)'(r_opc % 11 + 1);   // ADD to JR
      if (r_eq == 0)
         r_b = r_a;   // Equal compares now and then
      send_ready(opc, r_rel[alu_isa_pkg::REL_W-1:0], r_a, r_b);
   endtask

   task automatic broadcast
   (
      input logic                           we,
      input logic [alu_isa_pkg::REG_AW-1:0] addr,
      input logic [alu_isa_pkg::DATA_W-1:0] data
   );
      i_byp_valid   = 1'b1;
      i_byp_rd_we   = we;
      i_byp_rd_addr = addr;
      i_byp_data    = data;
      @(negedge clk);
      i_byp_valid   = 1'b0;
      i_byp_rd_we   = 1'b0;
   endtask

   task automatic wait_drain();
      while ((sent_tgl ^ done_tgl) != '0)
         @(negedge clk);
   endtask

   function automatic logic in_flight(input logic [alu_cfg_pkg::ROB_AW-1:0] id);
      return sent_tgl[id] ^ done_tgl[id];
   endfunction

   // Writeback ready, driven on the falling edge
   always @(negedge clk)
   begin
      if (ready_mode == 1)
      begin
         rdy_lfsr   = lfsr_next(rdy_lfsr);
         i_wb_ready = rdy_lfsr[0];   // Low about half the time
      end
      else
         i_wb_ready = (ready_mode == 0);
   end

   // Stall hold and scoreboard compare at each rising edge
   always @(posedge clk)
   begin
      if (hold_chk)
      begin
         if (o_wb_valid !== 1'b1)
         begin
            n_hold_err++;
            $display("Stalled result of id %0d was dropped before writeback took it", held_id);
         end
         if (o_wb_data !== held.data)
         begin
            n_hold_err++;
            $display("FAIL o_wb_data while stalled: got %h expected %h", o_wb_data, held.data);
         end
         if (o_wb_id !== held_id)
         begin
            n_hold_err++;
            $display("FAIL o_wb_id while stalled: got %h expected %h", o_wb_id, held_id);
         end
         if ({o_wb_branch_op, o_wb_branch_rel_taken, o_wb_branch_reg_taken}
             !== {held.br_op, held.rel_taken, held.reg_taken})
         begin
            n_hold_err++;
            $display("FAIL o_wb_branch_* while stalled: got %h expected %h",
                     {o_wb_branch_op, o_wb_branch_rel_taken, o_wb_branch_reg_taken},
                     {held.br_op, held.rel_taken, held.reg_taken});
         end
      end
      hold_chk = o_wb_valid && !i_wb_ready && !i_flush && !i_rst;
      held     = {o_wb_data, o_wb_branch_op, o_wb_branch_rel_taken, o_wb_branch_reg_taken};
      held_id  = o_wb_id;
      if (!i_rst && o_wb_valid && i_wb_ready)
      begin
         if (sent_tgl[o_wb_id] == done_tgl[o_wb_id])
         begin
            n_id_err++;
            $display("Writeback of id %0d, which is not in flight (duplicate or unexpected)",
                     o_wb_id);
         end
         else
         begin
            done_tgl[o_wb_id] = ~done_tgl[o_wb_id];
            n_wb++;
            if (o_wb_data !== exp_tab[o_wb_id].data)
            begin
               n_val_err++;
               $display("FAIL o_wb_data id %h: got %h expected %h",
                        o_wb_id, o_wb_data, exp_tab[o_wb_id].data);
            end
            if (o_wb_branch_op !== exp_tab[o_wb_id].br_op)
            begin
               n_val_err++;
               $display("FAIL o_wb_branch_op id %h: got %h expected %h",
                        o_wb_id, o_wb_branch_op, exp_tab[o_wb_id].br_op);
            end
            if (o_wb_branch_rel_taken !== exp_tab[o_wb_id].rel_taken)
            begin
               n_val_err++;
               $display("FAIL o_wb_branch_rel_taken id %h: got %h expected %h",
                        o_wb_id, o_wb_branch_rel_taken, exp_tab[o_wb_id].rel_taken);
            end
            if (o_wb_branch_reg_taken !== exp_tab[o_wb_id].reg_taken)
            begin
               n_val_err++;
               $display("FAIL o_wb_branch_reg_taken id %h: got %h expected %h",
                        o_wb_id, o_wb_branch_reg_taken, exp_tab[o_wb_id].reg_taken);
            end
         end
      end
   end

   always @(posedge clk)
   begin
      cycle++;
      if (cycle >= MAX_CYCLES)
      begin
         $display("Timeout: run stopped after %0d cycles", cycle);
         $display("** FAIL **");
         $finish;
      end
   end

   initial
   begin
      logic [alu_cfg_pkg::ROB_AW-1:0] wait_id;
      int                             wait_cnt;
      i_rst         = 1'b1;
      i_flush       = 1'b0;
      i_issue_valid = 1'b0;
      i_issue_uop   = '0;
      i_issue_id    = '0;
      i_rs1_rdy     = 1'b0;
      i_rs1_dat     = '0;
      i_rs1_addr    = '0;
      i_rs2_rdy     = 1'b0;
      i_rs2_dat     = '0;
      i_rs2_addr    = '0;
      i_byp_valid   = 1'b0;
      i_byp_data    = '0;
      i_byp_rd_we   = 1'b0;
      i_byp_rd_addr = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;
      if (o_issue_ready !== 1'b1 || o_wb_valid !== 1'b0)
      begin
         n_dir_err++;
         $display("FAIL o_issue_ready/o_wb_valid after reset: got %h/%h expected 1/0",
                  o_issue_ready, o_wb_valid);
      end

      // Random ALU and branch ops, writeback always ready
      repeat (140) send_random();
      wait_drain();

      // Both operands wait, then arrive on separate broadcasts
      send_uop(alu_isa_pkg::OPC_ADD, '0, 1'b0, 32'h1111_0000, 5'd1, 1'b0, 32'h2222, 5'd2, 1'b0);
      wait_id = last_id;
      repeat (4) @(negedge clk);
      broadcast(1'b1, 5'd1, 32'h1111_0000);
      repeat (4) @(negedge clk);
      if (!in_flight(wait_id))
      begin
         n_dir_err++;
         $display("Id %0d completed before its second operand was broadcast", wait_id);
      end
      broadcast(1'b1, 5'd2, 32'h2222);
      // Operand woken in its own accept cycle
      send_uop(alu_isa_pkg::OPC_SUB, '0, 1'b0, 32'hcafe_0001, 5'd3, 1'b1, 32'h1, 5'd0, 1'b1);
      // A broadcast without register write leaves the operand waiting
      send_uop(alu_isa_pkg::OPC_XOR, '0, 1'b1, 32'h0f0f_0f0f, 5'd0, 1'b0, 32'h1234_5678, 5'd4,
               1'b0);
      wait_id = last_id;
      broadcast(1'b0, 5'd4, 32'hdead_beef);
      repeat (4) @(negedge clk);
      if (!in_flight(wait_id))
      begin
         n_dir_err++;
         $display("Id %0d woke on a broadcast that carried no register write", wait_id);
      end
      broadcast(1'b1, 5'd4, 32'h1234_5678);
      wait_drain();

      // Branch compares and jump
      send_ready(alu_isa_pkg::OPC_BEQ, 15'h7ff0, 32'h55, 32'h55);   // Taken, negative offset
      send_ready(alu_isa_pkg::OPC_BEQ, 15'h0010, 32'h55, 32'h56);
      send_ready(alu_isa_pkg::OPC_BNE, 15'h4000, 32'h7, 32'h8);
      send_ready(alu_isa_pkg::OPC_BNE, 15'h0123, 32'h9, 32'h9);
      send_ready(alu_isa_pkg::OPC_JR, 15'h0abc, 32'h8000_1234, 32'h0);
      send_ready(alu_isa_pkg::OPC_NOP, 15'h1fff, 32'h1, 32'h2);
      wait_drain();

      // Random ops under writeback back-pressure
      ready_mode = 1;
      repeat (140) send_random();
      wait_drain();
      ready_mode = 0;

      // Fill the queue with waiting ops, one per address
      for (int k = 0; k < alu_cfg_pkg::IQ_DEPTH; k++)
      begin
         send_uop(alu_isa_pkg::OPC_ADD, '0, 1'b0, 32'h100 + k, 5'(10 + k), 1'b1, 32'h5, 5'd0,
                  1'b0);
         if (o_issue_ready !== (k < alu_cfg_pkg::IQ_DEPTH - 1))
         begin
            n_dir_err++;
            $display("FAIL o_issue_ready after %0d accepts: got %h expected %h",
                     k + 1, o_issue_ready, k < alu_cfg_pkg::IQ_DEPTH - 1);
         end
      end
      broadcast(1'b1, 5'd10, 32'h100);
      wait_cnt = 0;
      while (!o_issue_ready && wait_cnt < 8)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!o_issue_ready)
      begin
         n_dir_err++;
         $display("Queue stayed full after one entry woke and left");
      end
      for (int k = 1; k < alu_cfg_pkg::IQ_DEPTH; k++)
         broadcast(1'b1, 5'(10 + k), 32'h100 + k);
      wait_drain();

      // Flush with one result parked and three ops queued
      ready_mode = 2;
      send_ready(alu_isa_pkg::OPC_ADD, '0, 32'h10, 32'h20);
      send_uop(alu_isa_pkg::OPC_OR, '0, 1'b0, 32'h1, 5'd20, 1'b1, 32'h2, 5'd0, 1'b0);
      send_uop(alu_isa_pkg::OPC_AND, '0, 1'b1, 32'h3, 5'd0, 1'b0, 32'h4, 5'd21, 1'b0);
      send_ready(alu_isa_pkg::OPC_SUB, '0, 32'h30, 32'h8);   // Eligible, blocked by the stall
      @(negedge clk);
      i_flush = 1'b1;
      @(negedge clk);
      i_flush    = 1'b0;
      sent_tgl   = done_tgl;   // Flushed ids must never write back
      ready_mode = 0;
      @(negedge clk);
      if (o_wb_valid !== 1'b0 || o_issue_ready !== 1'b1)
      begin
         n_dir_err++;
         $display("FAIL o_wb_valid/o_issue_ready after flush: got %h/%h expected 0/1",
                  o_wb_valid, o_issue_ready);
      end
      send_ready(alu_isa_pkg::OPC_XOR, '0, 32'hffff_0000, 32'h0f0f_0f0f);
      wait_drain();
      repeat (10) @(negedge clk);   // Window for a stray writeback

      if ((sent_tgl ^ done_tgl) != '0)
      begin
         n_dir_err++;
         $display("%0d micro-ops never wrote back", $countones(sent_tgl ^ done_tgl));
      end
      $display("Errors: value %0d, id %0d, stall %0d, directed %0d; %0d writebacks checked",
               n_val_err, n_id_err, n_hold_err, n_dir_err, n_wb);
      if (n_val_err + n_id_err + n_hold_err + n_dir_err == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule
